//--- pcap_cfg.svh
`ifndef PCAP_CFG_SVH
`define PCAP_CFG_SVH

// ==========================================================================
// Stream and memory geometry
// ==========================================================================

// Bytes per stream beat
`define PCAP_DATA_BYTES 4

// Capture memory depth in words
`define PCAP_MEM_DEPTH 256

// Metadata field widths
`define PCAP_TID_W 8
`define PCAP_TDEST_W 12
`define PCAP_TUSER_W 32

// ==========================================================================
// Register port
// ==========================================================================

`define PCAP_REG_ADDR_W 9
`define PCAP_REG_DATA_W 32

`define PCAP_REG_MEM_SIZE     9'h000
`define PCAP_REG_META_WIDTH   9'h001
`define PCAP_REG_CONTROL      9'h002
`define PCAP_REG_STATUS       9'h003
`define PCAP_REG_LENGTH       9'h004
`define PCAP_REG_META_USER    9'h005
`define PCAP_REG_META_ID_DEST 9'h006

// Set for reads from the packet memory
`define PCAP_MEM_WINDOW_BIT 8

`endif

//--- axis_pkg.sv
`default_nettype none

`include "pcap_cfg.svh"

package axis_pkg;

    // Beat payload fields
    typedef logic [`PCAP_DATA_BYTES*8-1:0] axis_data_t;
    typedef logic [`PCAP_DATA_BYTES-1:0]   axis_keep_t;

    // Sideband fields
    typedef logic [`PCAP_TID_W-1:0]   axis_tid_t;
    typedef logic [`PCAP_TDEST_W-1:0] axis_tdest_t;
    typedef logic [`PCAP_TUSER_W-1:0] axis_tuser_t;

    // One stream beat, big-endian data, keep bit 3 is the first byte
    typedef struct packed {
        axis_data_t  data;
        axis_keep_t  keep;
        logic        last;
        axis_tid_t   tid;
        axis_tdest_t tdest;
        axis_tuser_t tuser;
    } axis_beat_t;

    // Per-packet metadata
    typedef struct packed {
        axis_tid_t   tid;
        axis_tdest_t tdest;
        axis_tuser_t tuser;
    } pcap_meta_t;

endpackage : axis_pkg

`default_nettype wire

//--- pcap_reg_pkg.sv
`default_nettype none

`include "pcap_cfg.svh"

package pcap_reg_pkg;

    // Register port
    typedef logic [`PCAP_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`PCAP_REG_DATA_W-1:0] reg_data_t;

    // Word address into the capture memory
    typedef logic [$clog2(`PCAP_MEM_DEPTH)-1:0] mem_addr_t;

    // Byte length, one extra bit so a full memory fits
    typedef logic [$clog2(`PCAP_MEM_DEPTH*`PCAP_DATA_BYTES):0] byte_len_t;

    // Status register content, overflow in bit 0
    typedef struct packed {
        logic busy;
        logic done;
        logic overflow;
    } pcap_status_t;

    // Capture sequence
    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        CAPTURE,
        DONE
    } cap_state_e;

endpackage : pcap_reg_pkg

`default_nettype wire

//--- pcap_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcap_cfg.svh"

module pcap_mem
    import axis_pkg::*;
    import pcap_reg_pkg::*;
(
    input  wire             clk,

    // Write side, from the writer
    input  wire             wr_en,
    input  wire mem_addr_t  wr_addr,
    input  wire axis_data_t wr_data,

    // Read side, from the control
    input  wire mem_addr_t  rd_addr,
    output axis_data_t      rd_data
);

    localparam int DEPTH = `PCAP_MEM_DEPTH;

    axis_data_t mem [DEPTH];

    // One write port, one registered read port
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule : pcap_mem

`default_nettype wire

//--- pcap_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcap_cfg.svh"

module pcap_writer
    import axis_pkg::*;
    import pcap_reg_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    // Stream input
    input  wire axis_beat_t s_beat,
    input  wire             s_valid,
    output logic            s_ready,

    // Control side
    input  wire             cap_enable,
    input  wire             cap_clear,
    output logic            cap_last_done,
    output byte_len_t       cap_len,
    output pcap_meta_t      cap_meta,
    output logic            cap_overflow,

    // Memory write port
    output logic            wr_en,
    output mem_addr_t       wr_addr,
    output axis_data_t      wr_data
);

    localparam mem_addr_t LAST_WORD = mem_addr_t'(`PCAP_MEM_DEPTH - 1);

    logic      accept;
    logic      take;
    logic      take_first;
    logic      mid_pkt;
    logic      started;
    logic      pkt_done;
    logic      mem_full;
    mem_addr_t word_addr;
    byte_len_t beat_bytes;

    // Count of valid bytes in a beat
    function automatic byte_len_t keep_bytes(input axis_keep_t keep);
        byte_len_t n;
        n = '0;
        for (int i = 0; i < `PCAP_DATA_BYTES; i++)
        begin
            n = n + byte_len_t'(keep[i]);
        end
        return n;
    endfunction

    assign accept     = s_valid && s_ready;
    assign beat_bytes = keep_bytes(s_beat.keep);

    // Only a packet that starts while enabled is captured, never a tail
    assign take       = accept && cap_enable && !pkt_done && (started || !mid_pkt);
    assign take_first = take && !started;

    assign wr_en   = take && (!started || !mem_full);
    assign wr_addr = started ? word_addr : '0;
    assign wr_data = s_beat.data;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s_ready       <= 1'b0;
            cap_last_done <= 1'b0;
            mid_pkt       <= 1'b0;
            started       <= 1'b0;
            pkt_done      <= 1'b0;
            mem_full      <= 1'b0;
            word_addr     <= '0;
            cap_len       <= '0;
            cap_meta      <= '0;
            cap_overflow  <= 1'b0;
        end
        else
        begin
            // No back-pressure once out of reset
            s_ready       <= 1'b1;
            cap_last_done <= take && s_beat.last;

            // Packet boundary tracking on all traffic
            if (accept)
            begin
                mid_pkt <= !s_beat.last;
            end

            if (cap_clear)
            begin
                started      <= 1'b0;
                pkt_done     <= 1'b0;
                mem_full     <= 1'b0;
                word_addr    <= '0;
                cap_len      <= '0;
                cap_meta     <= '0;
                cap_overflow <= 1'b0;
            end
            else if (!cap_enable)
            begin
                // Results hold for readback
                started  <= 1'b0;
                pkt_done <= 1'b0;
            end
            else if (take_first)
            begin
                started      <= 1'b1;
                pkt_done     <= s_beat.last;
                mem_full     <= 1'b0;
                word_addr    <= mem_addr_t'(1);
                cap_len      <= beat_bytes;
                cap_meta     <= '{tid: s_beat.tid, tdest: s_beat.tdest, tuser: s_beat.tuser};
                cap_overflow <= 1'b0;
            end
            else if (take)
            begin
                pkt_done <= s_beat.last;
                if (mem_full)
                begin
                    // Truncated beyond the last word
                    cap_overflow <= 1'b1;
                end
                else
                begin
                    cap_len <= cap_len + beat_bytes;
                    if (word_addr == LAST_WORD)
                    begin
                        mem_full <= 1'b1;
                    end
                    else
                    begin
                        word_addr <= word_addr + mem_addr_t'(1);
                    end
                end
            end
            else if (!started && !pkt_done)
            begin
                // Armed and waiting, old results dropped
                cap_len      <= '0;
                cap_meta     <= '0;
                cap_overflow <= 1'b0;
            end
        end
    end

endmodule : pcap_writer

`default_nettype wire

//--- pcap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcap_cfg.svh"

module pcap_ctrl
    import axis_pkg::*;
    import pcap_reg_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    // Register port
    input  wire reg_addr_t  reg_addr,
    input  wire reg_data_t  reg_wdata,
    input  wire             reg_wr,
    input  wire             reg_rd,
    output reg_data_t       reg_rdata,
    output logic            reg_rvalid,

    // Writer side
    output logic            cap_enable,
    output logic            cap_clear,
    input  wire             cap_last_done,
    input  wire byte_len_t  cap_len,
    input  wire pcap_meta_t cap_meta,
    input  wire             cap_overflow,

    // Memory read port
    output mem_addr_t       rd_addr,
    input  wire axis_data_t rd_data
);

    localparam int MEM_BYTES = `PCAP_MEM_DEPTH * `PCAP_DATA_BYTES;
    localparam int META_BITS = $bits(pcap_meta_t);

    cap_state_e   state;
    logic         arm_q;
    logic         ctrl_wr;
    logic         arm;
    pcap_status_t status;
    reg_data_t    sel_val;
    logic         rd_vld1;
    logic         rd_mem1;
    reg_data_t    rd_val1;

    // ======================================================================
    // Control writes and capture FSM
    // ======================================================================

    assign ctrl_wr   = reg_wr && (reg_addr == `PCAP_REG_CONTROL);
    assign arm       = ctrl_wr && reg_wdata[0];
    assign cap_clear = ctrl_wr && reg_wdata[1];

    assign cap_enable = (state == ARMED) || (state == CAPTURE);

    assign status.busy     = cap_enable;
    assign status.done     = (state == DONE);
    assign status.overflow = cap_overflow;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= IDLE;
            arm_q <= 1'b0;
        end
        else
        begin
            // Writer length is stale in the first armed cycle
            arm_q <= arm && !cap_clear && !cap_enable;

            if (cap_clear)
            begin
                state <= IDLE;
            end
            else
            begin
                case (state)
                    IDLE, DONE:
                    begin
                        if (arm)
                        begin
                            state <= ARMED;
                        end
                    end
                    ARMED:
                    begin
                        if (cap_last_done)
                        begin
                            state <= DONE;
                        end
                        else if (!arm_q && (cap_len != '0))
                        begin
                            state <= CAPTURE;
                        end
                    end
                    CAPTURE:
                    begin
                        if (cap_last_done)
                        begin
                            state <= DONE;
                        end
                    end
                    default:
                    begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // Read pipeline
    // ======================================================================

    // Memory sees the word index straight away
    assign rd_addr = mem_addr_t'(reg_addr);

    always_comb
    begin
        case (reg_addr)
            `PCAP_REG_MEM_SIZE:     sel_val = reg_data_t'(MEM_BYTES);
            `PCAP_REG_META_WIDTH:   sel_val = reg_data_t'(META_BITS);
            `PCAP_REG_STATUS:       sel_val = reg_data_t'(status);
            `PCAP_REG_LENGTH:       sel_val = reg_data_t'(cap_len);
            `PCAP_REG_META_USER:    sel_val = reg_data_t'(cap_meta.tuser);
            `PCAP_REG_META_ID_DEST: sel_val = reg_data_t'({cap_meta.tdest, cap_meta.tid});
            default:                sel_val = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_vld1    <= 1'b0;
            reg_rvalid <= 1'b0;
        end
        else
        begin
            rd_vld1    <= reg_rd;
            reg_rvalid <= rd_vld1;
        end
    end

    // Stage one register value, stage two memory or register
    always_ff @(posedge clk)
    begin
        rd_mem1   <= reg_addr[`PCAP_MEM_WINDOW_BIT];
        rd_val1   <= sel_val;
        reg_rdata <= rd_mem1 ? reg_data_t'(rd_data) : rd_val1;
    end

endmodule : pcap_ctrl

`default_nettype wire

//--- axi4s_packet_capture.sv
`timescale 1ns/1ps
`default_nettype none

module axi4s_packet_capture
    import axis_pkg::*;
    import pcap_reg_pkg::*;
(
    input  wire             clk,
    input  wire             arst_n,

    // Stream input
    input  wire axis_beat_t s_beat,
    input  wire             s_valid,
    output logic            s_ready,

    // Register port
    input  wire reg_addr_t  reg_addr,
    input  wire reg_data_t  reg_wdata,
    input  wire             reg_wr,
    input  wire             reg_rd,
    output reg_data_t       reg_rdata,
    output logic            reg_rvalid
);

    logic       cap_enable;
    logic       cap_clear;
    logic       cap_last_done;
    byte_len_t  cap_len;
    pcap_meta_t cap_meta;
    logic       cap_overflow;
    logic       wr_en;
    mem_addr_t  wr_addr;
    axis_data_t wr_data;
    mem_addr_t  rd_addr;
    axis_data_t rd_data;

    pcap_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_rdata     (reg_rdata),
        .reg_rvalid    (reg_rvalid),
        .cap_enable    (cap_enable),
        .cap_clear     (cap_clear),
        .cap_last_done (cap_last_done),
        .cap_len       (cap_len),
        .cap_meta      (cap_meta),
        .cap_overflow  (cap_overflow),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

    pcap_writer u_writer (
        .clk           (clk),
        .arst_n        (arst_n),
        .s_beat        (s_beat),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .cap_enable    (cap_enable),
        .cap_clear     (cap_clear),
        .cap_last_done (cap_last_done),
        .cap_len       (cap_len),
        .cap_meta      (cap_meta),
        .cap_overflow  (cap_overflow),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    pcap_mem u_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule : axi4s_packet_capture

`default_nettype wire

//--- pcap_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pcap_properties (
    input wire clk,
    input wire arst_n,
    input wire reg_rd,
    input wire reg_rvalid,
    input wire cap_enable,
    input wire wr_en,
    input wire s_ready,
    input wire busy,
    input wire done
);

    // Read answer comes exactly two cycles after the request
    rd_latency: assert property (@(posedge clk) disable iff (!arst_n)
        reg_rd |-> ##2 reg_rvalid)
        else $error("read valid missing two cycles after the request");

    rd_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
        reg_rvalid |-> $past(reg_rd, 2))
        else $error("read valid without a request two cycles earlier");

    // Memory writes only during a capture
    wr_in_capture: assert property (@(posedge clk) disable iff (!arst_n)
        wr_en |-> cap_enable)
        else $error("memory write while capture is not enabled");

    ready_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> s_ready)
        else $error("stream ready low after reset");

    busy_done_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(busy && done))
        else $error("busy and done set together");

endmodule : pcap_properties

// ==========================================================================
// Attachment to the control and the writer
// ==========================================================================

bind pcap_ctrl pcap_properties u_ctrl_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_rd     (reg_rd),
    .reg_rvalid (reg_rvalid),
    .cap_enable (cap_enable),
    .wr_en      (1'b0),
    .s_ready    (1'b1),
    .busy       (status.busy),
    .done       (status.done)
);

bind pcap_writer pcap_properties u_writer_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .reg_rd     (1'b0),
    .reg_rvalid (1'b0),
    .cap_enable (cap_enable),
    .wr_en      (wr_en),
    .s_ready    (s_ready),
    .busy       (1'b0),
    .done       (1'b0)
);

`default_nettype wire

//--- tb_axi4s_packet_capture.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcap_cfg.svh"

module tb_axi4s_packet_capture
    import axis_pkg::*;
    import pcap_reg_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int MEM_BYTES  = 1024;
    localparam int META_BITS  = 52;
    // 14 packets, at most 300 beats each, plus about 1000 register reads
    localparam int MAX_CYCLES = 20000;

    localparam reg_data_t STAT_OVERFLOW = 32'h1;
    localparam reg_data_t STAT_DONE     = 32'h2;
    localparam reg_data_t STAT_BUSY     = 32'h4;
    localparam reg_data_t CTRL_ARM      = 32'h1;
    localparam reg_data_t CTRL_CLEAR    = 32'h2;

    logic       clk;
    logic       arst_n;
    axis_beat_t s_beat;
    logic       s_valid;
    logic       s_ready;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    logic       reg_wr;
    logic       reg_rd;
    reg_data_t  reg_rdata;
    logic       reg_rvalid;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    reg_data_t rd_val;

    // Reference model, packet on the wire and packet held by the DUT
    logic [7:0]  pkt_bytes[$];
    axis_tid_t   pkt_tid;
    axis_tdest_t pkt_tdest;
    axis_tuser_t pkt_tuser;
    logic [7:0]  cap_bytes[$];
    axis_tid_t   cap_tid;
    axis_tdest_t cap_tdest;
    axis_tuser_t cap_tuser;

    axi4s_packet_capture uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic compare(input string name, input reg_data_t expected,
                           input reg_data_t actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(negedge clk);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        @(negedge clk);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(negedge clk);
        reg_rd   = 1'b0;
        @(negedge clk);
        if (!reg_rvalid)
        begin
            errors++;
            $display("Read of register %h was not acknowledged after 2 cycles", addr);
        end
        data = reg_rdata;
    endtask

    task automatic make_packet(input int lo, input int hi);
        int n;
        n = lo + ($unsigned($random(seed)) % (hi - lo + 1));
        pkt_bytes.delete();
        for (int i = 0; i < n; i++)
        begin
            pkt_bytes.push_back(8'($random(seed)));
        end
        pkt_tid   = axis_tid_t'($random(seed));
        pkt_tdest = axis_tdest_t'($random(seed));
        pkt_tuser = axis_tuser_t'($random(seed));
    endtask

    // Big-endian lanes, unused lanes of the last beat carry junk
    task automatic send_packet();
        int n;
        int beats;
        int idx;
        n     = pkt_bytes.size();
        beats = (n + 3) / 4;
        @(negedge clk);
        for (int b = 0; b < beats; b++)
        begin
            if (($random(seed) & 7) == 0)
            begin
                s_valid = 1'b0;
                @(negedge clk);
            end
            s_beat.data  = axis_data_t'($random(seed));
            s_beat.keep  = '0;
            s_beat.last  = (b == beats - 1);
            s_beat.tid   = pkt_tid;
            s_beat.tdest = pkt_tdest;
            s_beat.tuser = pkt_tuser;
            for (int k = 0; k < 4; k++)
            begin
                idx = 4 * b + k;
                if (idx < n)
                begin
                    s_beat.data[31 - 8 * k -: 8] = pkt_bytes[idx];
                    s_beat.keep[3 - k]           = 1'b1;
                end
            end
            s_valid = 1'b1;
            // Stream is never throttled
            compare("stream ready", 32'h1, reg_data_t'(s_ready));
            @(negedge clk);
        end
        s_valid = 1'b0;
    endtask

    task automatic wait_for_done();
        reg_data_t st;
        for (int i = 0; i < 10; i++)
        begin
            read_reg(`PCAP_REG_STATUS, st);
            if (st & STAT_DONE)
            begin
                return;
            end
        end
        errors++;
        $display("Capture did not complete, done never appeared in status");
    endtask

    task automatic verify_capture(input string name);
        int        len;
        int        idx;
        reg_data_t exp_word;
        reg_data_t mask;
        reg_data_t act;
        reg_data_t exp_stat;
        len      = (cap_bytes.size() > MEM_BYTES) ? MEM_BYTES : cap_bytes.size();
        exp_stat = STAT_DONE | ((cap_bytes.size() > MEM_BYTES) ? STAT_OVERFLOW : '0);
        read_reg(`PCAP_REG_STATUS, act);
        compare({name, " status"}, exp_stat, act);
        read_reg(`PCAP_REG_LENGTH, act);
        compare({name, " length"}, reg_data_t'(len), act);
        read_reg(`PCAP_REG_META_USER, act);
        compare({name, " tuser"}, reg_data_t'(cap_tuser), act);
        read_reg(`PCAP_REG_META_ID_DEST, act);
        compare({name, " tid/tdest"}, reg_data_t'({cap_tdest, cap_tid}), act);
        for (int w = 0; w < (len + 3) / 4; w++)
        begin
            exp_word = '0;
            mask     = '0;
            for (int k = 0; k < 4; k++)
            begin
                idx = 4 * w + k;
                if (idx < len)
                begin
                    exp_word[31 - 8 * k -: 8] = cap_bytes[idx];
                    mask[31 - 8 * k -: 8]     = 8'hff;
                end
            end
            read_reg(reg_addr_t'((1 << `PCAP_MEM_WINDOW_BIT) | w), act);
            compare($sformatf("%s word %0d", name, w), exp_word, act & mask);
        end
    endtask

    task automatic keep_packet();
        cap_bytes = pkt_bytes;
        cap_tid   = pkt_tid;
        cap_tdest = pkt_tdest;
        cap_tuser = pkt_tuser;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        seed      = 50555;
        arst_n    = 1'b0;
        s_beat    = '0;
        s_valid   = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Information registers
        read_reg(`PCAP_REG_MEM_SIZE, rd_val);
        compare("mem size", reg_data_t'(MEM_BYTES), rd_val);
        read_reg(`PCAP_REG_META_WIDTH, rd_val);
        compare("meta width", reg_data_t'(META_BITS), rd_val);
        read_reg(`PCAP_REG_STATUS, rd_val);
        compare("reset status", '0, rd_val);

        // Traffic while idle is dropped
        make_packet(16, 200);
        send_packet();
        repeat (3) @(negedge clk);
        read_reg(`PCAP_REG_STATUS, rd_val);
        compare("idle status", '0, rd_val);
        read_reg(`PCAP_REG_LENGTH, rd_val);
        compare("idle length", '0, rd_val);
        read_reg(`PCAP_REG_META_USER, rd_val);
        compare("idle tuser", '0, rd_val);
        read_reg(`PCAP_REG_META_ID_DEST, rd_val);
        compare("idle tid/tdest", '0, rd_val);

        // Single capture
        write_reg(`PCAP_REG_CONTROL, CTRL_ARM);
        read_reg(`PCAP_REG_STATUS, rd_val);
        compare("armed status", STAT_BUSY, rd_val);
        make_packet(16, 200);
        keep_packet();
        send_packet();
        wait_for_done();
        verify_capture("single");

        // Second packet without re-arm leaves the first one in place
        make_packet(16, 200);
        send_packet();
        repeat (3) @(negedge clk);
        verify_capture("no rearm");

        for (int r = 0; r < 10; r++)
        begin
            write_reg(`PCAP_REG_CONTROL, CTRL_ARM);
            make_packet(16, 200);
            keep_packet();
            send_packet();
            wait_for_done();
            verify_capture($sformatf("rearm %0d", r));
        end

        // Packet longer than the memory
        write_reg(`PCAP_REG_CONTROL, CTRL_ARM);
        make_packet(1100, 1200);
        keep_packet();
        send_packet();
        wait_for_done();
        verify_capture("overflow");

        // Clear
        write_reg(`PCAP_REG_CONTROL, CTRL_CLEAR);
        read_reg(`PCAP_REG_STATUS, rd_val);
        compare("clear status", '0, rd_val);
        read_reg(`PCAP_REG_LENGTH, rd_val);
        compare("clear length", '0, rd_val);
        read_reg(`PCAP_REG_META_USER, rd_val);
        compare("clear tuser", '0, rd_val);
        read_reg(`PCAP_REG_META_ID_DEST, rd_val);
        compare("clear tid/tdest", '0, rd_val);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_axi4s_packet_capture

`default_nettype wire

//--- axi4s_packet_capture.f
+incdir+.
axis_pkg.sv
pcap_reg_pkg.sv
pcap_mem.sv
pcap_writer.sv
pcap_ctrl.sv
axi4s_packet_capture.sv
pcap_properties.sv
tb_axi4s_packet_capture.sv
